// File: design/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data and address width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_AW 5

`define RV_RESET_PC 32'h0000_0000

// Sequential fetch step in bytes
`define RV_INST_STEP 32'd4

`endif

// File: design/rv_isa_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_isa_pkg;

  typedef enum logic [6:0] {
    OP_R       = 7'b0110011,
    OP_I_ARITH = 7'b0010011,
    OP_LOAD    = 7'b0000011,
    OP_STORE   = 7'b0100011,
    OP_BRANCH  = 7'b1100011,
    OP_LUI     = 7'b0110111,
    OP_JAL     = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_f3_e;

  // Bit 3 set means subtract
  typedef enum logic [3:0] {
    ALU_ADD = 4'b0000,
    ALU_AND = 4'b0001,
    ALU_OR  = 4'b0010,
    ALU_XOR = 4'b0011,
    ALU_SLL = 4'b0100,
    ALU_SUB = 4'b1000
  } alu_op_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm_11_0;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_11_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_4_0;
    opcode_e               opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    branch_f3_e            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    opcode_e               opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]           imm_31_12;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } j_fmt_t;

  // One instruction word, six ways to read it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

endpackage

`default_nettype wire

// File: design/rv_pipe_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pipe_pkg;

  typedef struct packed {
    logic                reg_write;
    logic                alu_src_imm;  // Operand b from immediate
    logic                mem_read;
    logic                mem_write;
    logic                mem_to_reg;
    logic                branch;
    logic                jal;
    logic                lui;          // Operand a forced to zero
    rv_isa_pkg::alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic [`RV_XLEN-1:0]   imm;
  } id_ex_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_to_reg;
    logic                  jal;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   alu_result;
    logic [`RV_XLEN-1:0]   store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                  reg_write;
    logic                  mem_to_reg;
    logic                  jal;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   alu_result;
    logic [`RV_XLEN-1:0]   load_data;
  } mem_wb_t;

  // Where a decode operand comes from
  typedef enum logic [2:0] {
    FWD_REGFILE,
    FWD_EX_ALU,
    FWD_MEM_LOAD,
    FWD_MEM_ALU,
    FWD_WB_DATA
  } fwd_sel_e;

endpackage

`default_nettype wire

// File: design/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_decoder (
  input  rv_isa_pkg::inst_u  inst,
  output rv_pipe_pkg::ctrl_t ctrl
);
  import rv_isa_pkg::*;

  always_comb
  begin
    ctrl = '0;  // Unknown opcode stays inactive
    ctrl.alu_op = ALU_ADD;
    case (inst.r_fmt.opcode)
      OP_R:
      begin
        ctrl.reg_write = 1'b1;
        case ({inst.r_fmt.funct7, inst.r_fmt.funct3})
          10'b0000000_000: ctrl.alu_op = ALU_ADD;
          10'b0100000_000: ctrl.alu_op = ALU_SUB;
          10'b0000000_111: ctrl.alu_op = ALU_AND;
          10'b0000000_110: ctrl.alu_op = ALU_OR;
          10'b0000000_001: ctrl.alu_op = ALU_SLL;
          default:         ctrl.alu_op = ALU_ADD;  // R-type xor not supported
        endcase
      end
      OP_I_ARITH:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        case (inst.i_fmt.funct3)
          3'b001:  ctrl.alu_op = ALU_SLL;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b110:  ctrl.alu_op = ALU_OR;
          3'b111:  ctrl.alu_op = ALU_AND;
          default: ctrl.alu_op = ALU_ADD;
        endcase
      end
      OP_LOAD:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
      end
      OP_STORE:
      begin
        ctrl.alu_src_imm = 1'b1;  // Address is rs1 plus S immediate
        ctrl.mem_write   = 1'b1;
      end
      OP_BRANCH: ctrl.branch = 1'b1;
      OP_LUI:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.lui         = 1'b1;
      end
      OP_JAL:
      begin
        ctrl.reg_write = 1'b1;  // Link written in writeback
        ctrl.jal       = 1'b1;
      end
      default: ctrl.alu_op = ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  we,
  input  logic [`RV_REG_AW-1:0] rs1_addr,
  input  logic [`RV_REG_AW-1:0] rs2_addr,
  input  logic [`RV_REG_AW-1:0] rd_addr,
  input  logic [`RV_XLEN-1:0]   rd_data,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  logic [`RV_XLEN-1:0] regs [2**`RV_REG_AW];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      regs <= '{default: '0};
    else if (we && rd_addr != '0)  // x0 never written
      regs[rd_addr] <= rd_data;
  end

  // Same-cycle write is covered by writeback forwarding
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// File: design/rv_branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_branch_unit (
  input  rv_pipe_pkg::ctrl_t      ctrl,
  input  rv_isa_pkg::branch_f3_e  funct3,
  input  logic [`RV_XLEN-1:0]     rs1_val,
  input  logic [`RV_XLEN-1:0]     rs2_val,
  input  logic [`RV_XLEN-1:0]     pc,
  input  logic [`RV_XLEN-1:0]     imm,
  output logic                    take_branch,
  output logic [`RV_XLEN-1:0]     target
);
  import rv_isa_pkg::*;

  logic [`RV_XLEN:0] diff;
  logic              n_flag, z_flag, c_flag, v_flag;
  logic              cond;

  // rs1 + ~rs2 + 1, carry out set when rs1 >= rs2 unsigned
  assign diff   = {1'b0, rs1_val} + {1'b0, ~rs2_val} + 1'b1;
  assign n_flag = diff[`RV_XLEN-1];
  assign z_flag = (diff[`RV_XLEN-1:0] == '0);
  assign c_flag = diff[`RV_XLEN];
  assign v_flag = (rs1_val[`RV_XLEN-1] != rs2_val[`RV_XLEN-1]) &&
                  (diff[`RV_XLEN-1] != rs1_val[`RV_XLEN-1]);

  always_comb
  begin
    case (funct3)
      BR_BEQ:  cond = z_flag;
      BR_BNE:  cond = !z_flag;
      BR_BLT:  cond = (n_flag != v_flag);
      BR_BGE:  cond = (n_flag == v_flag);
      BR_BLTU: cond = !c_flag;
      BR_BGEU: cond = c_flag;
      default: cond = 1'b0;
    endcase
  end

  assign take_branch = ctrl.jal || (ctrl.branch && cond);
  assign target      = pc + imm;  // imm is the B or J immediate

endmodule

`default_nettype wire

// File: design/rv_hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_hazard_unit (
  input  logic [`RV_REG_AW-1:0]  rs1,
  input  logic [`RV_REG_AW-1:0]  rs2,
  input  rv_pipe_pkg::id_ex_t    id_ex,
  input  rv_pipe_pkg::ex_mem_t   ex_mem,
  input  rv_pipe_pkg::mem_wb_t   mem_wb,
  output logic                   stall,
  output rv_pipe_pkg::fwd_sel_e  fwd_rs1,
  output rv_pipe_pkg::fwd_sel_e  fwd_rs2
);
  import rv_pipe_pkg::*;

  // Youngest writer of rs wins, x0 always from the register file
  function automatic fwd_sel_e pick_source(
    input logic [`RV_REG_AW-1:0] rs,
    input id_ex_t                ex_stage,
    input ex_mem_t               mem_stage,
    input mem_wb_t               wb_stage
  );
    fwd_sel_e sel;
    sel = FWD_REGFILE;
    if (rs == '0)
      sel = FWD_REGFILE;
    else if (ex_stage.ctrl.reg_write && ex_stage.rd == rs)
      sel = FWD_EX_ALU;
    else if (mem_stage.reg_write && mem_stage.rd == rs)
    begin
      // Load data arrives combinationally this cycle
      if (mem_stage.mem_read)
        sel = FWD_MEM_LOAD;
      else
        sel = FWD_MEM_ALU;
    end
    else if (wb_stage.reg_write && wb_stage.rd == rs)
      sel = FWD_WB_DATA;
    return sel;
  endfunction

  // Load in execute cannot forward yet, hold decode one cycle
  assign stall = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                 ((id_ex.rd == rs1) || (id_ex.rd == rs2));

  always_comb
  begin
    fwd_rs1 = pick_source(rs1, id_ex, ex_mem, mem_wb);
    fwd_rs2 = pick_source(rs2, id_ex, ex_mem, mem_wb);
  end

endmodule

`default_nettype wire

// File: design/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_alu (
  input  rv_isa_pkg::alu_op_e  op,
  input  logic [`RV_XLEN-1:0]  a,
  input  logic [`RV_XLEN-1:0]  b,
  output logic [`RV_XLEN-1:0]  result
);
  import rv_isa_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];  // Only the low five bits shift

  always_comb
  begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLL: result = a << shamt;
      default: result = a + b;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_cpu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_cpu (
  input  logic                clk,
  input  logic                reset,
  output logic [`RV_XLEN-1:0] pc,
  input  rv_isa_pkg::inst_u   inst,
  output logic                mem_write,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [`RV_XLEN-1:0] mem_wdata,
  input  logic [`RV_XLEN-1:0] mem_rdata
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  inst_u               if_id_inst;
  logic [`RV_XLEN-1:0] if_id_pc;
  id_ex_t              id_ex, id_ex_d;
  ex_mem_t             ex_mem;
  mem_wb_t             mem_wb;

  ctrl_t               dec_ctrl;
  logic [`RV_XLEN-1:0] dec_imm, rf_rs1, rf_rs2, op_rs1, op_rs2;
  logic                stall, take_branch, redirect;
  logic [`RV_XLEN-1:0] br_target;
  fwd_sel_e            fwd_rs1, fwd_rs2;
  logic [`RV_XLEN-1:0] alu_a, alu_b, alu_result;
  logic [`RV_XLEN-1:0] ex_fwd, mem_fwd, wb_data;

  function automatic logic [`RV_XLEN-1:0] fwd_mux(
    input fwd_sel_e            sel,
    input logic [`RV_XLEN-1:0] rf_val,
    input logic [`RV_XLEN-1:0] ex_val,
    input logic [`RV_XLEN-1:0] load_val,
    input logic [`RV_XLEN-1:0] mem_val,
    input logic [`RV_XLEN-1:0] wb_val
  );
    case (sel)
      FWD_EX_ALU:   return ex_val;
      FWD_MEM_LOAD: return load_val;
      FWD_MEM_ALU:  return mem_val;
      FWD_WB_DATA:  return wb_val;
      default:      return rf_val;
    endcase
  endfunction

  assign redirect = take_branch && !stall;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= `RV_RESET_PC;
    else if (!stall)
      pc <= redirect ? br_target : pc + `RV_INST_STEP;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      if_id_inst <= '0;
      if_id_pc   <= '0;
    end
    else if (!stall)
    begin
      if_id_inst <= redirect ? inst_u'('0) : inst;  // Zero word decodes as bubble
      if_id_pc   <= pc;
    end
  end

  rv_decoder u_decoder (.inst(if_id_inst), .ctrl(dec_ctrl));

  rv_regfile u_regfile (
    .clk(clk), .reset(reset), .we(mem_wb.reg_write),
    .rs1_addr(if_id_inst.r_fmt.rs1), .rs2_addr(if_id_inst.r_fmt.rs2),
    .rd_addr(mem_wb.rd), .rd_data(wb_data),
    .rs1_data(rf_rs1), .rs2_data(rf_rs2)
  );

  rv_hazard_unit u_hazard (
    .rs1(if_id_inst.r_fmt.rs1), .rs2(if_id_inst.r_fmt.rs2),
    .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
    .stall(stall), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2)
  );

  // One immediate per format
  always_comb
  begin
    case (if_id_inst.r_fmt.opcode)
      OP_STORE:  dec_imm = {{(`RV_XLEN-12){if_id_inst.s_fmt.imm_11_5[6]}},
                            if_id_inst.s_fmt.imm_11_5, if_id_inst.s_fmt.imm_4_0};
      OP_BRANCH: dec_imm = {{(`RV_XLEN-12){if_id_inst.b_fmt.imm_12}},
                            if_id_inst.b_fmt.imm_11, if_id_inst.b_fmt.imm_10_5,
                            if_id_inst.b_fmt.imm_4_1, 1'b0};
      OP_LUI:    dec_imm = {if_id_inst.u_fmt.imm_31_12, 12'b0};
      OP_JAL:    dec_imm = {{(`RV_XLEN-20){if_id_inst.j_fmt.imm_20}},
                            if_id_inst.j_fmt.imm_19_12, if_id_inst.j_fmt.imm_11,
                            if_id_inst.j_fmt.imm_10_1, 1'b0};
      default:   dec_imm = {{(`RV_XLEN-12){if_id_inst.i_fmt.imm_11_0[11]}},
                            if_id_inst.i_fmt.imm_11_0};
    endcase
  end

  assign op_rs1 = fwd_mux(fwd_rs1, rf_rs1, ex_fwd, mem_rdata, mem_fwd, wb_data);
  assign op_rs2 = fwd_mux(fwd_rs2, rf_rs2, ex_fwd, mem_rdata, mem_fwd, wb_data);

  rv_branch_unit u_branch (
    .ctrl(dec_ctrl), .funct3(if_id_inst.b_fmt.funct3),
    .rs1_val(op_rs1), .rs2_val(op_rs2), .pc(if_id_pc), .imm(dec_imm),
    .take_branch(take_branch), .target(br_target)
  );

  always_comb
  begin
    id_ex_d.ctrl     = stall ? ctrl_t'('0) : dec_ctrl;  // Bubble on load-use
    id_ex_d.pc       = if_id_pc;
    id_ex_d.rd       = if_id_inst.r_fmt.rd;
    id_ex_d.rs1_data = op_rs1;
    id_ex_d.rs2_data = op_rs2;
    id_ex_d.imm      = dec_imm;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex <= '0;
    else
      id_ex <= id_ex_d;
  end

  assign alu_a = id_ex.ctrl.lui ? '0 : id_ex.rs1_data;
  assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rs2_data;

  rv_alu u_alu (.op(id_ex.ctrl.alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

  // A jal in flight forwards its link value
  assign ex_fwd = id_ex.ctrl.jal ? id_ex.pc + `RV_INST_STEP : alu_result;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ex_mem <= '0;
    else
    begin
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem.jal        <= id_ex.ctrl.jal;
      ex_mem.pc         <= id_ex.pc;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= id_ex.rs2_data;
    end
  end

  assign mem_write = ex_mem.mem_write;
  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;
  assign mem_fwd   = ex_mem.jal ? ex_mem.pc + `RV_INST_STEP : ex_mem.alu_result;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mem_wb <= '0;
    else
    begin
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
      mem_wb.jal        <= ex_mem.jal;
      mem_wb.pc         <= ex_mem.pc;
      mem_wb.rd         <= ex_mem.rd;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.load_data  <= mem_rdata;
    end
  end

  assign wb_data = mem_wb.jal        ? mem_wb.pc + `RV_INST_STEP :
                   mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: verification/tb_program_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module tb_program_mem #(
  parameter logic [31:0] SEED = 32'h8fc8_d17d
) (
  input  logic                clk,
  input  logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] inst,
  input  logic                mem_write,
  input  logic [`RV_XLEN-1:0] mem_addr,
  input  logic [`RV_XLEN-1:0] mem_wdata,
  output logic [`RV_XLEN-1:0] mem_rdata
);

  logic [31:0] rom [128];
  logic [31:0] ram [256];
  int          prog_len;
  int          st_off;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd, input logic [6:0] op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2, input int rs1);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
  endfunction

  task automatic emit(input logic [31:0] w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  // Store rs2 to the next result slot above x10
  task automatic store(input int rs2);
    emit(enc_s(12'(st_off), rs2, 10));
    st_off += 4;
  endtask

  // Taken branch skips the poison store and the second branch falls through
  task automatic br_pair(input logic [2:0] f3, input int t1, input int t2,
                         input int n1, input int n2);
    emit(enc_b(13'd8, t2, t1, f3));
    emit(enc_s(12'd0, 13, 10));
    store(11);
    emit(enc_b(13'd8, n2, n1, f3));
    store(12);
  endtask

  initial
  begin
    logic [31:0] s;
    s = SEED;
    for (int i = 0; i < 256; i++)
      ram[i] = 32'h5a00_0000 ^ (i * 32'h0001_0101);  // Fill unique per word
    for (int i = 0; i < 8; i++)
    begin
      s = lcg_next(s);
      ram[i] = s;
    end
    for (int i = 0; i < 128; i++)
      rom[i] = enc_i(12'(i), 0, 3'b000, 0, 7'h13);  // Nops that differ per word
    prog_len = 0;
    st_off = 0;
    emit(enc_j(21'd8, 17));                        // Link 4 into x17
    emit(enc_s(12'd0, 13, 10));                    // Skipped by the jal
    for (int r = 1; r <= 4; r++)
      emit(enc_i(12'((r - 1) * 4), 0, 3'b010, r, 7'h03));
    emit(enc_i(12'h100, 0, 3'b000, 10, 7'h13));
    emit(enc_i(-12'sd5, 0, 3'b000, 11, 7'h13));
    emit(enc_i(12'd3, 0, 3'b000, 12, 7'h13));
    emit({20'hDEAD0, 5'd13, 7'h37});               // Poison marker
    emit(enc_r(7'h00, 2, 1, 3'b000, 5));
    store(5);
    emit(enc_r(7'h20, 2, 1, 3'b000, 5));
    store(5);
    emit(enc_r(7'h00, 2, 1, 3'b111, 5));
    store(5);
    emit(enc_r(7'h00, 2, 1, 3'b110, 5));
    store(5);
    emit(enc_r(7'h00, 2, 1, 3'b001, 5));
    store(5);
    emit(enc_i(-12'sd123, 1, 3'b000, 5, 7'h13));
    store(5);
    emit(enc_i(12'h5a5, 1, 3'b111, 5, 7'h13));
    store(5);
    emit(enc_i(12'h900, 1, 3'b110, 5, 7'h13));
    store(5);
    emit(enc_i(12'h3c3, 1, 3'b100, 5, 7'h13));
    store(5);
    emit(enc_i(12'd7, 1, 3'b001, 5, 7'h13));
    store(5);
    // Forwarding at distances one, two and three
    emit(enc_r(7'h00, 2, 1, 3'b000, 6));
    emit(enc_r(7'h00, 3, 6, 3'b000, 7));
    store(7);
    emit(enc_r(7'h00, 4, 3, 3'b000, 6));
    emit(32'h0000_0013);
    emit(enc_r(7'h00, 1, 6, 3'b000, 7));
    store(7);
    emit(enc_r(7'h00, 4, 1, 3'b000, 6));
    emit(32'h0000_0013);
    emit(32'h0000_0013);
    emit(enc_r(7'h00, 2, 6, 3'b000, 7));
    store(7);
    emit(enc_i(12'd16, 0, 3'b010, 9, 7'h03));
    emit(enc_r(7'h00, 1, 9, 3'b000, 9));
    store(9);
    emit(enc_i(12'd20, 0, 3'b010, 9, 7'h03));
    store(9);                                      // Load-use on store data
    br_pair(3'b000, 11, 11, 11, 12);
    br_pair(3'b001, 11, 12, 11, 11);
    br_pair(3'b100, 11, 12, 12, 11);
    br_pair(3'b101, 12, 11, 11, 12);
    br_pair(3'b110, 12, 11, 11, 12);
    br_pair(3'b111, 11, 12, 12, 11);
    store(17);
    emit({20'h12345, 5'd15, 7'h37});
    store(15);
    emit({20'hABCDE, 5'd16, 7'h37});
    emit(enc_i(12'h678, 16, 3'b000, 16, 7'h13));
    store(16);
    emit(enc_j(21'd0, 0));                         // Self-loop
  end

  assign inst      = rom[pc[8:2]];
  assign mem_rdata = ram[mem_addr[9:2]];

  always @(posedge clk)
  begin
    if (mem_write)
      ram[mem_addr[9:2]] <= mem_wdata;
  end

endmodule

`default_nettype wire

// File: verification/tb_rv_cpu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module tb_rv_cpu;

  localparam int          PERIOD    = 40;
  localparam int          RESET_CYC = 5;
  localparam logic [31:0] POISON    = 32'hDEAD_0000;

  logic                clk, reset, reset_q, mem_write;
  logic [`RV_XLEN-1:0] pc, inst, mem_addr, mem_wdata, mem_rdata;
  logic [31:0]         d [8];
  logic [31:0]         exp_addr [64];
  logic [31:0]         exp_data [64];
  int                  exp_grp [64];
  int                  n_exp, store_idx, reported, errors, failed_tests;
  int                  grp_err [6];
  string               grp_name [6];

  tb_clock_gen #(.PERIOD(PERIOD)) u_clk (.clk(clk));

  tb_program_mem u_mem (
    .clk(clk), .pc(pc), .inst(inst), .mem_write(mem_write),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  rv_cpu i_dut (
    .clk(clk), .reset(reset), .pc(pc), .inst(inst), .mem_write(mem_write),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  task automatic expect_store(input int grp, input logic [31:0] value);
    exp_addr[n_exp] = 32'h100 + 4 * n_exp;
    exp_data[n_exp] = value;
    exp_grp[n_exp]  = grp;
    n_exp++;
  endtask

  task automatic count_error(input int grp);
    errors++;
    grp_err[grp]++;
  endtask

  task automatic report_test(input int grp);
    if (grp_err[grp] == 0)
      $display("Test %s: PASS", grp_name[grp]);
    else
    begin
      $display("Test %s: FAIL with %0d mismatches", grp_name[grp], grp_err[grp]);
      failed_tests++;
    end
  endtask

  always_ff @(posedge clk)
    reset_q <= reset;

  always @(posedge clk)
  begin
    if (!reset && mem_write)
      store_idx <= store_idx + 1;
  end

  a_reset_state: assert property (@(posedge clk) (reset || reset_q) |->
                                  (pc == `RV_RESET_PC && !mem_write))
    else
    begin
      $display("FAIL reset: expected pc %h mem_write 0, actual pc %h mem_write %b",
               `RV_RESET_PC, $sampled(pc), $sampled(mem_write));
      count_error(0);
    end

  a_store_count: assert property (@(posedge clk) disable iff (reset)
                                  mem_write |-> store_idx < n_exp)
    else
    begin
      $display("Unexpected extra store to address %h", $sampled(mem_addr));
      count_error(exp_grp[n_exp - 1]);
    end

  a_store_value: assert property (@(posedge clk) disable iff (reset)
                                  (mem_write && store_idx < n_exp) |->
                                  (mem_addr == exp_addr[store_idx] &&
                                   mem_wdata == exp_data[store_idx]))
    else
    begin
      $display("FAIL %s: store %0d expected %h at %h, actual %h at %h",
               grp_name[exp_grp[$sampled(store_idx)]], $sampled(store_idx),
               exp_data[$sampled(store_idx)], exp_addr[$sampled(store_idx)],
               $sampled(mem_wdata), $sampled(mem_addr));
      count_error(exp_grp[$sampled(store_idx)]);
    end

  // Wrong-path stores carry the poison marker
  a_no_poison: assert property (@(posedge clk) disable iff (reset)
                                mem_write |-> mem_wdata != POISON)
    else
    begin
      $display("Wrong-path store executed at address %h", $sampled(mem_addr));
      count_error(4);
    end

  // Report a group once its last store has been checked
  always @(negedge clk)
  begin
    while (reported < store_idx && reported < n_exp)
    begin
      if (reported == n_exp - 1 || exp_grp[reported + 1] != exp_grp[reported])
        report_test(exp_grp[reported]);
      reported++;
    end
  end

  initial
  begin
    reset = 1'b1;
    n_exp = 0;
    store_idx = 0;
    reported = 0;
    errors = 0;
    failed_tests = 0;
    grp_err = '{default: 0};
    grp_name = '{"reset", "alu", "forwarding", "load_use", "control_flow", "jal_lui"};
    #1;
    for (int i = 0; i < 8; i++)
      d[i] = u_mem.ram[i];
    expect_store(1, d[0] + d[1]);
    expect_store(1, d[0] - d[1]);
    expect_store(1, d[0] & d[1]);
    expect_store(1, d[0] | d[1]);
    expect_store(1, d[0] << d[1][4:0]);
    expect_store(1, d[0] - 32'd123);
    expect_store(1, d[0] & 32'h0000_05a5);
    expect_store(1, d[0] | 32'hFFFF_F900);
    expect_store(1, d[0] ^ 32'h0000_03c3);
    expect_store(1, d[0] << 7);
    expect_store(2, d[0] + d[1] + d[2]);
    expect_store(2, d[2] + d[3] + d[0]);
    expect_store(2, d[0] + d[3] + d[1]);
    expect_store(3, d[4] + d[0]);
    expect_store(3, d[5]);
    for (int b = 0; b < 6; b++)
    begin
      expect_store(4, 32'hFFFF_FFFB);  // Taken path marker
      expect_store(4, 32'd3);          // Fall-through marker
    end
    expect_store(5, 32'd4);            // jal at address 0 links to 4
    expect_store(5, 32'h1234_5000);
    expect_store(5, 32'hABCD_E678);
    repeat (RESET_CYC) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);
    report_test(0);
    while (pc != 4 * (u_mem.prog_len - 1))
      @(negedge clk);
    repeat (4) @(negedge clk);
    a_final_count: assert (store_idx == n_exp)
      else
      begin
        $display("Store count wrong before the self-loop, %0d of %0d seen",
                 store_idx, n_exp);
        count_error(5);
      end
    $display("Summary: %0d tests, %0d failed, %0d mismatches", 6, failed_tests, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // Limit scales with program length
  initial
  begin
    #1;
    #((u_mem.prog_len * 3 + RESET_CYC) * PERIOD);
    $display("Watchdog expired, the program never reached its self-loop");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_branch_unit.sv
design/rv_hazard_unit.sv
design/rv_alu.sv
design/rv_cpu.sv
verification/tb_clock_gen.sv
verification/tb_program_mem.sv
verification/tb_rv_cpu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_cpu
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
